/* Bender.yml */
package:
  name: io_buffer

sources:
  - source/io_buffer_pkg.sv
  - source/agu_config.sv
  - source/agu_level.sv
  - source/agu.sv
  - source/sram_2port.sv
  - source/io_buffer.sv
  - target: test
    files:
      - tb/io_buffer_props.sv
      - tb/io_buffer_tb.sv

/* all.f */
source/io_buffer_pkg.sv
source/agu_config.sv
source/agu_level.sv
source/agu.sv
source/sram_2port.sv
source/io_buffer.sv
tb/io_buffer_props.sv
tb/io_buffer_tb.sv

/* source/agu.sv */
`timescale 1ns/1ps

module agu #(
  parameter int ADDR_WIDTH = 16,
  parameter int AGU_PORT   = 0
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  io_buffer_pkg::resource_ctrl_t ctrl,
  output logic                          addr_valid,
  output logic [ADDR_WIDTH-1:0]         addr
);

  localparam int NL = io_buffer_pkg::NUM_LEVELS;

  logic                              start;
  logic                              running;
  logic                              freeze;
  logic                              emit;
  logic                              done;
  logic [ADDR_WIDTH-1:0]             init_addr;
  io_buffer_pkg::rep_t [NL-1:0]      level_cfg;
  logic [NL-1:0]                     tick;
  logic [NL-1:0]                     last;
  logic [NL-1:0]                     stall;
  logic [NL-1:0][ADDR_WIDTH-1:0]     offset;
  logic [ADDR_WIDTH-1:0]             addr_sum;

  assign start  = ctrl.activate[AGU_PORT];
  assign freeze = |stall;
  assign emit   = running && !freeze;

  // Carry out of the outermost level ends the walk
  assign done = emit && tick[NL-1] && last[NL-1];

  agu_config #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .AGU_PORT  (AGU_PORT)
  ) u_config (
    .clk      (clk),
    .rst_n    (rst_n),
    .instr_en (ctrl.instr_en),
    .instr    (ctrl.instr),
    .init_addr(init_addr),
    .level_cfg(level_cfg)
  );

  for (genvar l = 0; l < NL; l++) begin : g_level
    if (l == 0) begin : g_first
      assign tick[l] = running;
    end else begin : g_carry
      assign tick[l] = tick[l-1] && last[l-1];
    end

    agu_level #(
      .ADDR_WIDTH(ADDR_WIDTH)
    ) u_level (
      .clk   (clk),
      .rst_n (rst_n),
      .start (start),
      .tick  (tick[l]),
      .freeze(freeze),
      .cfg   (level_cfg[l]),
      .last  (last[l]),
      .stall (stall[l]),
      .offset(offset[l])
    );
  end

  always_comb begin
    addr_sum = init_addr;
    for (int l = 0; l < NL; l++) begin
      addr_sum = addr_sum + offset[l];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running    <= 1'b0;
      addr_valid <= 1'b0;
      addr       <= '0;
    end else if (start) begin
      // Restart also covers a running walk
      running    <= 1'b1;
      addr_valid <= 1'b0;
    end else begin
      addr_valid <= emit;
      if (emit) begin
        addr <= addr_sum;
      end
      if (done) begin
        running <= 1'b0;
      end
    end
  end

endmodule

/* source/agu_config.sv */
`timescale 1ns/1ps

module agu_config #(
  parameter int ADDR_WIDTH = 16,
  parameter int AGU_PORT   = 0
) (
  input  logic                                               clk,
  input  logic                                               rst_n,
  input  logic                                               instr_en,
  input  io_buffer_pkg::instr_t                              instr,
  output logic [ADDR_WIDTH-1:0]                              init_addr,
  output io_buffer_pkg::rep_t [io_buffer_pkg::NUM_LEVELS-1:0] level_cfg
);

  localparam logic [io_buffer_pkg::PORT_SEL_WIDTH-1:0] PORT_ID =
    io_buffer_pkg::PORT_SEL_WIDTH'(AGU_PORT);

  io_buffer_pkg::dsu_t dsu;
  io_buffer_pkg::rep_t rep;
  logic                dsu_hit;
  logic                rep_hit;

  assign dsu = instr.payload.dsu;
  assign rep = instr.payload.rep;

  // Only instructions addressed to this port are taken
  assign dsu_hit = instr_en && (instr.opcode == io_buffer_pkg::OP_DSU) &&
                   (dsu.port == PORT_ID);
  assign rep_hit = instr_en && (instr.opcode == io_buffer_pkg::OP_REP) &&
                   (rep.port == PORT_ID);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      init_addr <= '0;
    end else if (dsu_hit) begin
      init_addr <= ADDR_WIDTH'(dsu.init_addr);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      level_cfg <= '0;
    end else if (rep_hit) begin
      level_cfg[rep.level] <= rep;
    end
  end

endmodule

/* source/agu_level.sv */
`timescale 1ns/1ps

module agu_level #(
  parameter int ADDR_WIDTH = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  logic                  tick,
  input  logic                  freeze,
  input  io_buffer_pkg::rep_t   cfg,
  output logic                  last,
  output logic                  stall,
  output logic [ADDR_WIDTH-1:0] offset
);

  logic [io_buffer_pkg::FIELD_WIDTH-1:0] idx;
  logic [io_buffer_pkg::FIELD_WIDTH-1:0] delay_cnt;
  logic                                  advance;

  // Level runs iter + 1 times
  assign last  = (idx == cfg.iter);
  assign stall = (delay_cnt != '0);

  // A stall anywhere holds every level
  assign advance = tick && !freeze;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx    <= '0;
      offset <= '0;
    end else if (start) begin
      idx    <= '0;
      offset <= '0;
    end else if (advance) begin
      if (last) begin
        idx    <= '0;
        offset <= '0;
      end else begin
        idx    <= idx + 1'b1;
        offset <= offset + ADDR_WIDTH'(cfg.step);
      end
    end
  end

  // Idle gap after a non-wrapping step
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      delay_cnt <= '0;
    end else if (start) begin
      delay_cnt <= '0;
    end else if (advance && !last) begin
      delay_cnt <= cfg.delay;
    end else if (stall) begin
      delay_cnt <= delay_cnt - 1'b1;
    end
  end

endmodule

/* source/io_buffer.sv */
`timescale 1ns/1ps

module io_buffer #(
  parameter int IO_AW   = io_buffer_pkg::IO_ADDR_WIDTH,
  parameter int SRAM_AW = io_buffer_pkg::SRAM_ADDR_WIDTH,
  parameter int DATA_W  = io_buffer_pkg::BULK_WIDTH
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  io_buffer_pkg::resource_ctrl_t ctrl_0,
  input  io_buffer_pkg::resource_ctrl_t ctrl_1,
  output logic                          io_en,
  output logic [IO_AW-1:0]              io_addr,
  input  logic [DATA_W-1:0]             io_data,
  output logic                          bulk_valid,
  output logic [DATA_W-1:0]             bulk_out
);

  logic               wr_valid;
  logic [SRAM_AW-1:0] wr_addr;
  logic               rd_valid;
  logic [SRAM_AW-1:0] rd_addr;
  logic [DATA_W-1:0]  rd_data;

  // Port 0 requests words from IO memory
  agu #(
    .ADDR_WIDTH(IO_AW),
    .AGU_PORT  (0)
  ) u_agu_io (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl_0),
    .addr_valid(io_en),
    .addr      (io_addr)
  );

  // Port 2 places returning IO words
  agu #(
    .ADDR_WIDTH(SRAM_AW),
    .AGU_PORT  (2)
  ) u_agu_wr (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl_0),
    .addr_valid(wr_valid),
    .addr      (wr_addr)
  );

  agu #(
    .ADDR_WIDTH(SRAM_AW),
    .AGU_PORT  (3)
  ) u_agu_rd (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl_1),
    .addr_valid(rd_valid),
    .addr      (rd_addr)
  );

  sram_2port #(
    .ADDR_WIDTH(SRAM_AW),
    .DATA_WIDTH(DATA_W)
  ) u_sram (
    .clk  (clk),
    .we   (wr_valid),
    .waddr(wr_addr),
    .wdata(io_data),
    .re   (rd_valid),
    .raddr(rd_addr),
    .rdata(rd_data)
  );

  // Read data lags the read address by one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bulk_valid <= 1'b0;
    end else begin
      bulk_valid <= rd_valid;
    end
  end

  assign bulk_out = bulk_valid ? rd_data : '0;

endmodule

/* source/io_buffer_pkg.sv */
package io_buffer_pkg;

  localparam int INSTR_WIDTH     = 32;
  localparam int OPCODE_WIDTH    = 3;
  localparam int PAYLOAD_WIDTH   = INSTR_WIDTH - OPCODE_WIDTH;
  localparam int FIELD_WIDTH     = 6;
  localparam int NUM_LEVELS      = 4;
  localparam int LEVEL_SEL_WIDTH = 2;
  localparam int PORT_SEL_WIDTH  = 2;
  localparam int IO_ADDR_WIDTH   = 16;
  localparam int SRAM_ADDR_WIDTH = 6;
  localparam int BULK_WIDTH      = 256;

  localparam logic [OPCODE_WIDTH-1:0] OP_REP = 3'd0;
  localparam logic [OPCODE_WIDTH-1:0] OP_DSU = 3'd6;

  // Initial address of one port
  typedef struct packed {
    logic [PORT_SEL_WIDTH-1:0] port;
    logic [IO_ADDR_WIDTH-1:0]  init_addr;
    logic [10:0]               pad;
  } dsu_t;

  // Settings of one loop level of one port
  typedef struct packed {
    logic [PORT_SEL_WIDTH-1:0]  port;
    logic [LEVEL_SEL_WIDTH-1:0] level;
    logic [FIELD_WIDTH-1:0]     iter;
    logic [FIELD_WIDTH-1:0]     step;
    logic [FIELD_WIDTH-1:0]     delay;
    logic [6:0]                 pad;
  } rep_t;

  // Opcode picks the view
  typedef union packed {
    dsu_t dsu;
    rep_t rep;
  } payload_t;

  typedef struct packed {
    logic [OPCODE_WIDTH-1:0] opcode;
    payload_t                payload;
  } instr_t;

  typedef struct packed {
    logic       instr_en;
    instr_t     instr;
    logic [3:0] activate;
  } resource_ctrl_t;

endpackage

/* source/sram_2port.sv */
`timescale 1ns/1ps

module sram_2port #(
  parameter int ADDR_WIDTH = 6,
  parameter int DATA_WIDTH = 256
) (
  input  logic                  clk,
  input  logic                  we,
  input  logic [ADDR_WIDTH-1:0] waddr,
  input  logic [DATA_WIDTH-1:0] wdata,
  input  logic                  re,
  input  logic [ADDR_WIDTH-1:0] raddr,
  output logic [DATA_WIDTH-1:0] rdata
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Same-address collision reads the old word
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[raddr];
    end else begin
      rdata <= '0;
    end
  end

endmodule

/* tb/io_buffer_props.sv */
`timescale 1ns/1ps

module io_buffer_props #(
  parameter int DATA_W = io_buffer_pkg::BULK_WIDTH
) (
  input logic              clk,
  input logic              rst_n,
  input logic              io_en,
  input logic              rd_valid,
  input logic              bulk_valid,
  input logic [DATA_W-1:0] bulk_out
);

  bulk_zero_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n) !bulk_valid |-> (bulk_out == '0)
  ) else $error("bulk_out is nonzero while bulk_valid is low");

  // Read data lags the port 3 address by one cycle
  bulk_valid_rise: assert property (
    @(posedge clk) disable iff (!rst_n) rd_valid |=> bulk_valid
  ) else $error("bulk_valid did not follow a port 3 read");

  bulk_valid_fall: assert property (
    @(posedge clk) disable iff (!rst_n) !rd_valid |=> !bulk_valid
  ) else $error("bulk_valid high without a port 3 read");

  io_en_reset: assert property (
    @(posedge clk) !rst_n |-> !io_en
  ) else $error("io_en high during reset");

endmodule

bind io_buffer io_buffer_props #(
  .DATA_W(DATA_W)
) u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .io_en     (io_en),
  .rd_valid  (rd_valid),
  .bulk_valid(bulk_valid),
  .bulk_out  (bulk_out)
);

/* tb/io_buffer_tb.sv */
`timescale 1ns/1ps

module io_buffer_tb;

  localparam int CLK_PERIOD = 8;
  localparam int IO_AW      = io_buffer_pkg::IO_ADDR_WIDTH;
  localparam int SRAM_AW    = io_buffer_pkg::SRAM_ADDR_WIDTH;
  localparam int DW         = io_buffer_pkg::BULK_WIDTH;

  // Limit well above the roughly 110 cycles the tests take
  localparam int WATCHDOG_CYCLES = 2500;

  // Extended rep opcode that the design ignores
  localparam logic [io_buffer_pkg::OPCODE_WIDTH-1:0] OP_REPX = 3'd1;

  logic                          clk;
  logic                          rst_n;
  io_buffer_pkg::resource_ctrl_t ctrl_0;
  io_buffer_pkg::resource_ctrl_t ctrl_1;
  logic                          io_en;
  logic [IO_AW-1:0]              io_addr;
  logic [DW-1:0]                 io_data;
  logic                          bulk_valid;
  logic [DW-1:0]                 bulk_out;

  int            seed = 48;
  int            value_errors;
  int            other_errors;
  int            got_val[$];
  int            got_cyc[$];
  int            exp_val[$];
  int            exp_cyc[$];
  logic [DW-1:0] got_word[$];
  logic [DW-1:0] words[8];

  io_buffer #(
    .IO_AW  (IO_AW),
    .SRAM_AW(SRAM_AW),
    .DATA_W (DW)
  ) u_io_buffer (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl_0    (ctrl_0),
    .ctrl_1    (ctrl_1),
    .io_en     (io_en),
    .io_addr   (io_addr),
    .io_data   (io_data),
    .bulk_valid(bulk_valid),
    .bulk_out  (bulk_out)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic io_buffer_pkg::instr_t dsu_instr(input int port, input int init);
    io_buffer_pkg::instr_t ins;
    io_buffer_pkg::dsu_t   d;
    d               = '0;
    d.port          = port[1:0];
    d.init_addr     = init[15:0];
    ins.opcode      = io_buffer_pkg::OP_DSU;
    ins.payload.dsu = d;
    return ins;
  endfunction

  function automatic io_buffer_pkg::instr_t rep_instr(input logic [2:0] opcode, input int port,
                                                      input int level, input int iter,
                                                      input int step, input int delay);
    io_buffer_pkg::instr_t ins;
    io_buffer_pkg::rep_t   r;
    r               = '0;
    r.port          = port[1:0];
    r.level         = level[1:0];
    r.iter          = iter[5:0];
    r.step          = step[5:0];
    r.delay         = delay[5:0];
    ins.opcode      = opcode;
    ins.payload.rep = r;
    return ins;
  endfunction

  // Every drive task starts and ends 1 ns after a rising edge
  task automatic send(input int ch, input io_buffer_pkg::instr_t ins, input logic en);
    if (ch == 0) begin
      ctrl_0.instr_en = en;
      ctrl_0.instr    = ins;
    end else begin
      ctrl_1.instr_en = en;
      ctrl_1.instr    = ins;
    end
    @(posedge clk);
    #1;
    ctrl_0.instr_en = 1'b0;
    ctrl_0.instr    = '0;
    ctrl_1.instr_en = 1'b0;
    ctrl_1.instr    = '0;
  endtask

  task automatic activate(input int port);
    if (port == 3) begin
      ctrl_1.activate[3] = 1'b1;
    end else begin
      ctrl_0.activate[port] = 1'b1;
    end
    @(posedge clk);
    #1;
    ctrl_0.activate = '0;
    ctrl_1.activate = '0;
  endtask

  // Cycle 0 is the one right after the activate edge
  task automatic capture_io(input int n, input int limit);
    got_val.delete();
    got_cyc.delete();
    for (int cyc = 0; cyc < limit && got_val.size() < n; cyc++) begin
      @(negedge clk);
      if (io_en) begin
        got_val.push_back(int'(io_addr));
        got_cyc.push_back(cyc);
      end
    end
    if (got_val.size() < n) begin
      other_errors++;
      $display("Timed out at %0t ns waiting for io_en, got %0d of %0d addresses",
               $time, got_val.size(), n);
    end
  endtask

  task automatic compare_io(input string tag);
    for (int i = 0; i < got_val.size(); i++) begin
      if (got_val[i] != exp_val[i]) begin
        value_errors++;
        $display("Fail at %0t ns: %s io_addr #%0d is %0d, expected %0d",
                 $time, tag, i, got_val[i], exp_val[i]);
      end
      if (got_cyc[i] != exp_cyc[i]) begin
        value_errors++;
        $display("Fail at %0t ns: %s address #%0d came in cycle %0d, expected %0d",
                 $time, tag, i, got_cyc[i], exp_cyc[i]);
      end
    end
    @(negedge clk);
    if (io_en) begin
      other_errors++;
      $display("%s: io_en stayed high after the last address", tag);
    end
    @(posedge clk);
    #1;
  endtask

  // Level 0 walk with delay and a cleared level 1 so no earlier walk leaves a trace
  task automatic configure_stream();
    send(0, dsu_instr(0, 100), 1'b1);
    send(0, rep_instr(io_buffer_pkg::OP_REP, 0, 0, 3, 5, 2), 1'b1);
    send(0, rep_instr(io_buffer_pkg::OP_REP, 0, 1, 0, 0, 0), 1'b1);
    exp_val.delete();
    exp_cyc.delete();
    for (int i = 0; i <= 3; i++) begin
      exp_val.push_back(100 + i * 5);
      exp_cyc.push_back(1 + i * (2 + 1));
    end
  endtask

  task automatic idle_after_reset();
    for (int cyc = 0; cyc < 20; cyc++) begin
      @(negedge clk);
      if (io_en || bulk_valid) begin
        value_errors++;
        $display("Fail at %0t ns: io_en %b bulk_valid %b while idle", $time, io_en, bulk_valid);
      end
    end
    @(posedge clk);
    #1;
  endtask

  task automatic single_stream();
    configure_stream();
    activate(0);
    capture_io(4, 40);
    compare_io("single stream");
  endtask

  task automatic nested_loops();
    send(0, dsu_instr(0, 200), 1'b1);
    send(0, rep_instr(io_buffer_pkg::OP_REP, 0, 0, 1, 1, 0), 1'b1);
    send(0, rep_instr(io_buffer_pkg::OP_REP, 0, 1, 2, 16, 0), 1'b1);
    exp_val.delete();
    exp_cyc.delete();
    for (int j = 0; j <= 2; j++) begin
      for (int i = 0; i <= 1; i++) begin
        exp_val.push_back(200 + i * 1 + j * 16);
        exp_cyc.push_back(1 + exp_cyc.size());
      end
    end
    activate(0);
    capture_io(6, 30);
    compare_io("nested");
  endtask

  task automatic write_then_read();
    for (int i = 0; i < 8; i++) begin
      for (int j = 0; j < DW / 32; j++) begin
        words[i][j*32 +: 32] = $random(seed);
      end
    end
    send(0, dsu_instr(2, 8), 1'b1);
    send(0, rep_instr(io_buffer_pkg::OP_REP, 2, 0, 7, 1, 0), 1'b1);
    activate(2);
    // Port 2 is valid for 8 cycles starting one cycle after the activate edge
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      #1;
      io_data = words[i];
    end
    @(posedge clk);
    #1;
    io_data = '0;
    send(1, dsu_instr(3, 8), 1'b1);
    send(1, rep_instr(io_buffer_pkg::OP_REP, 3, 0, 7, 1, 0), 1'b1);
    activate(3);
    got_word.delete();
    got_cyc.delete();
    for (int cyc = 0; cyc < 30 && got_word.size() < 8; cyc++) begin
      @(negedge clk);
      if (bulk_valid) begin
        got_word.push_back(bulk_out);
        got_cyc.push_back(cyc);
      end
    end
    if (got_word.size() < 8) begin
      other_errors++;
      $display("Timed out at %0t ns waiting for bulk_valid, got %0d of 8 words",
               $time, got_word.size());
    end
    for (int i = 0; i < got_word.size(); i++) begin
      if (got_word[i] !== words[i]) begin
        value_errors++;
        $display("Fail at %0t ns: bulk word #%0d is %h, expected %h",
                 $time, i, got_word[i], words[i]);
      end
      if (got_cyc[i] != 2 + i) begin
        value_errors++;
        $display("Fail at %0t ns: bulk word #%0d came in cycle %0d, expected %0d",
                 $time, i, got_cyc[i], 2 + i);
      end
    end
    @(posedge clk);
    #1;
  endtask

  task automatic instruction_filter();
    configure_stream();
    send(0, rep_instr(io_buffer_pkg::OP_REP, 3, 0, 1, 1, 0), 1'b1);
    send(0, rep_instr(OP_REPX, 0, 0, 1, 9, 0), 1'b1);
    send(0, dsu_instr(0, 999), 1'b0);
    activate(0);
    capture_io(4, 40);
    compare_io("filter");
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    ctrl_0       = '0;
    ctrl_1       = '0;
    io_data      = '0;
    value_errors = 0;
    other_errors = 0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    idle_after_reset();
    single_stream();
    nested_loops();
    write_then_read();
    instruction_filter();
    $display("Value errors: %0d, other failures: %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles before the tests completed", WATCHDOG_CYCLES);
    $display("Value errors: %0d, other failures: %0d", value_errors, other_errors);
    $display("Finished with errors");
    $finish;
  end

endmodule
